//--- src.f
+incdir+include
verilog/cpu_pkg.sv
verilog/cpu_fetch.sv
verilog/cpu_decode.sv
verilog/cpu_execute.sv
verilog/cpu_memory.sv
verilog/cpu_top.sv
dv/cpu_props.sv
dv/cpu_tb.sv

//--- dv/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module cpu_tb import cpu_pkg::*; ();

  localparam int MAXCYCLES = 2000;

  // Register roles in the test programs
  // R0 is never written and reads as zero
  localparam logic [3:0] RZERO = 4'd0;
  localparam logic [3:0] RA    = 4'd1;
  localparam logic [3:0] RB    = 4'd3;
  localparam logic [3:0] RACC  = 4'd4;
  localparam logic [3:0] RRES  = 4'd5;
  localparam logic [3:0] RTMP  = 4'd13;
  localparam logic [3:0] RC24  = 4'd14;
  localparam logic [3:0] RC16  = 4'd15;

  logic                     clk;
  logic                     reset;
  imem_load_t               imem_load;
  logic [`CPU_KEYBITS-1:0]  key;
  logic [`CPU_SWBITS-1:0]   sw;
  logic [`CPU_HEXBITS-1:0]  hex;
  logic [`CPU_LEDRBITS-1:0] ledr;

  logic [31:0] lfsr_state;
  logic [31:0] prog [$];

  cpu_top i_dut (
    .clk(clk), .reset(reset), .imem_load(imem_load), .key(key), .sw(sw),
    .hex(hex), .ledr(ledr)
  );

  always #50 clk = ~clk;

  // **********************************************************
  // Random source and failure reporting
  // **********************************************************
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // Instruction encoders
  function automatic logic [31:0] enc_alur(input op2_e op2, input logic [3:0] rd,
                                           input logic [3:0] rs, input logic [3:0] rt);
    return {OP1_ALUR, op2, 6'b0, rd, rs, rt};
  endfunction

  // rt is the destination or the store source
  function automatic logic [31:0] enc_imm(input op1_e op1, input logic [15:0] imm,
                                          input logic [3:0] rs, input logic [3:0] rt);
    return {op1, 2'b00, imm, rs, rt};
  endfunction

  // **********************************************************
  // Reference model
  // **********************************************************
  function automatic logic [31:0] alu_model(input op2_e op2, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op2)
      OP2_EQ:   return (a == b) ? 32'd1 : 32'd0;
      OP2_LT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP2_LE:   return ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
      OP2_NE:   return (a != b) ? 32'd1 : 32'd0;
      OP2_ADD:  return a + b;
      OP2_AND:  return a & b;
      OP2_OR:   return a | b;
      OP2_XOR:  return a ^ b;
      OP2_SUB:  return a - b;
      OP2_NAND: return ~(a & b);
      OP2_NOR:  return ~(a | b);
      OP2_NXOR: return ~(a ^ b);
      OP2_RSHF: return a >> b[4:0];
      OP2_LSHF: return a << b[4:0];
      default:  return '0;
    endcase
  endfunction

  function automatic logic [31:0] imm_model(input op1_e op1, input logic [31:0] a,
                                            input logic [15:0] imm);
    logic [31:0] sx;
    sx = {{16{imm[15]}}, imm};
    case (op1)
      OP1_ADDI: return a + sx;
      OP1_ANDI: return a & sx;
      OP1_ORI:  return a | sx;
      OP1_XORI: return a ^ sx;
      default:  return '0;
    endcase
  endfunction

  function automatic logic taken_model(input op1_e op1, input logic [31:0] a,
                                       input logic [31:0] b);
    case (op1)
      OP1_BEQ: return a == b;
      OP1_BLT: return $signed(a) < $signed(b);
      OP1_BLE: return $signed(a) <= $signed(b);
      OP1_BNE: return a != b;
      default: return 1'b0;
    endcase
  endfunction

  // Top byte folded into the 24 visible bits
  function automatic logic [`CPU_HEXBITS-1:0] hex_fold(input logic [31:0] acc);
    return 24'(acc ^ (acc >> 24));
  endfunction

  // **********************************************************
  // Program assembly and execution
  // **********************************************************
  task automatic push_word(input logic [31:0] word);
    prog.push_back(word);
  endtask

  // PC of the next pushed word
  function automatic logic [31:0] word_pc();
    return `CPU_STARTPC + prog.size() * 4;
  endfunction

  // Shift constants 16 and 24
  task automatic start_program();
    prog.delete();
    push_word(enc_imm(OP1_ADDI, 16'd16, RZERO, RC16));
    push_word(enc_imm(OP1_ADDI, 16'd24, RZERO, RC24));
  endtask

  // Upper half pre-corrected for the sign-extended lower half
  task automatic build_const(input logic [3:0] rn, input logic [31:0] v);
    logic [15:0] hi;
    hi = v[31:16] + {15'b0, v[15]};
    push_word(enc_imm(OP1_ADDI, hi, RZERO, rn));
    push_word(enc_alur(OP2_LSHF, rn, rn, RC16));
    push_word(enc_imm(OP1_ADDI, v[15:0], RZERO, RTMP));
    push_word(enc_alur(OP2_ADD, rn, rn, RTMP));
  endtask

  // Fold RACC, store to HEX, then spin on a self-branch
  task automatic finish_program();
    push_word(enc_alur(OP2_RSHF, RRES, RACC, RC24));
    push_word(enc_alur(OP2_XOR, RACC, RACC, RRES));
    push_word(enc_imm(OP1_SW, 16'(`CPU_ADDRHEX), RZERO, RACC));
    push_word(enc_imm(OP1_BEQ, 16'hFFFF, RZERO, RZERO));
  endtask

  // Load under reset, release, wait for HEX to move
  task automatic load_and_run(input logic [`CPU_HEXBITS-1:0] exp_hex);
    int cycles;
    reset = 1'b1;
    foreach (prog[i]) begin
      imem_load.en   = 1'b1;
      imem_load.addr = 16'(`CPU_STARTPC + 4 * i);
      imem_load.inst = prog[i];
      @(negedge clk);
    end
    imem_load = '0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    cycles = 0;
    while (hex === `CPU_HEXRESET) begin
      if (cycles == MAXCYCLES) begin
        $display("timeout: hex never changed after %0d cycles", MAXCYCLES);
        abort_run();
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
    check_value("hex", hex, exp_hex);
  endtask

  // **********************************************************
  // Directed tests
  // **********************************************************
  task automatic check_reset_values();
    reset = 1'b1;
    @(negedge clk);
    check_value("hex", hex, `CPU_HEXRESET);
    check_value("ledr", ledr, '0);
  endtask

  // Each result feeds the next XOR, so decode stalls every time
  task automatic alu_reg_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] acc;
    op2_e        op;
    do begin
      take_bits(32, a);
      take_bits(32, b);
      acc = '0;
      op = op.first();
      for (int i = 0; i < op.num(); i++) begin
        acc = (acc << 1) ^ alu_model(op, a, b);
        op = op.next();
      end
    end while (hex_fold(acc) === `CPU_HEXRESET);
    start_program();
    build_const(RA, a);
    build_const(RB, b);
    op = op.first();
    for (int i = 0; i < op.num(); i++) begin
      push_word(enc_alur(op, RRES, RA, RB));
      // Doubling gives each result its own bit position
      push_word(enc_alur(OP2_ADD, RACC, RACC, RACC));
      push_word(enc_alur(OP2_XOR, RACC, RACC, RRES));
      op = op.next();
    end
    finish_program();
    load_and_run(hex_fold(acc));
  endtask

  task automatic alu_imm_ops();
    logic [31:0] a;
    logic [31:0] acc;
    logic [31:0] r;
    logic [15:0] imm [8];
    op1_e        ops [4];
    ops = '{OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI};
    do begin
      take_bits(32, a);
      acc = '0;
      for (int i = 0; i < 8; i++) begin
        take_bits(15, r);
        // Even slots negative, odd slots positive
        imm[i] = {(i % 2 == 0), r[14:0]};
        acc = acc ^ imm_model(ops[i / 2], a, imm[i]);
      end
    end while (hex_fold(acc) === `CPU_HEXRESET);
    start_program();
    build_const(RA, a);
    for (int i = 0; i < 8; i++) begin
      push_word(enc_imm(ops[i / 2], imm[i], RA, RRES));
      push_word(enc_alur(OP2_XOR, RACC, RACC, RRES));
    end
    finish_program();
    load_and_run(hex_fold(acc));
  endtask

  // Two adjacent words, read back and subtracted
  task automatic load_store();
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] base;
    logic [31:0] led;
    do begin
      take_bits(32, v1);
      take_bits(32, v2);
    end while (hex_fold(v1 - v2) === `CPU_HEXRESET);
    take_bits(13, base);
    base = base << 2;
    take_bits(32, led);
    start_program();
    build_const(RA, v1);
    build_const(RB, v2);
    push_word(enc_imm(OP1_ADDI, base[15:0], RZERO, 4'd6));
    push_word(enc_imm(OP1_SW, 16'd0, 4'd6, RA));
    push_word(enc_imm(OP1_SW, 16'd4, 4'd6, RB));
    push_word(enc_imm(OP1_LW, 16'd0, 4'd6, 4'd7));
    push_word(enc_imm(OP1_LW, 16'd4, 4'd6, 4'd8));
    push_word(enc_alur(OP2_SUB, RACC, 4'd7, 4'd8));
    // LEDR store lands before the HEX store
    build_const(4'd11, led);
    push_word(enc_imm(OP1_SW, 16'(`CPU_ADDRLEDR), RZERO, 4'd11));
    finish_program();
    load_and_run(hex_fold(v1 - v2));
    check_value("ledr", ledr, led[9:0]);
  endtask

  // Marker bit k sits right after branch k
  task automatic branches_and_jal();
    logic [31:0] r;
    logic [15:0] neg;
    logic [15:0] pos;
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] acc;
    logic [31:0] jal_pc;
    op1_e        br_op [8];
    logic [3:0]  br_rs [8];
    logic [3:0]  br_rt [8];
    br_op = '{OP1_BEQ, OP1_BEQ, OP1_BLT, OP1_BLT, OP1_BLE, OP1_BLE, OP1_BNE, OP1_BNE};
    br_rs = '{RA, RA, RA, RB, RA, RB, RA, RA};
    br_rt = '{RA, RB, RB, RA, RA, RA, RB, RA};
    // Negative vs positive, unsigned order disagrees
    take_bits(15, r);
    neg = {1'b1, r[14:0]};
    take_bits(15, r);
    pos = {1'b0, r[14:0]};
    x = {{16{1'b1}}, neg};
    y = {16'b0, pos};
    acc = '0;
    start_program();
    push_word(enc_imm(OP1_ADDI, neg, RZERO, RA));
    push_word(enc_imm(OP1_ADDI, pos, RZERO, RB));
    for (int k = 0; k < 8; k++) begin
      push_word(enc_imm(br_op[k], 16'd1, br_rs[k], br_rt[k]));
      push_word(enc_imm(OP1_ADDI, 16'(1 << k), RACC, RACC));
      a = (br_rs[k] == RA) ? x : y;
      b = (br_rt[k] == RA) ? x : y;
      if (!taken_model(br_op[k], a, b)) begin
        acc = acc | (32'd1 << k);
      end
    end
    // JAL off r10, landing past a marker of 0x100
    push_word(enc_imm(OP1_ADDI, 16'h0080, RZERO, 4'd10));
    jal_pc = word_pc();
    push_word(enc_imm(OP1_JAL, 16'((jal_pc + 32'd8 - 32'h80) >> 2), 4'd10, 4'd9));
    push_word(enc_imm(OP1_ADDI, 16'h0100, RACC, RACC));
    push_word(enc_alur(OP2_LSHF, 4'd9, 4'd9, RC16));
    push_word(enc_alur(OP2_XOR, RACC, RACC, 4'd9));
    finish_program();
    acc = acc ^ ((jal_pc + 32'd4) << 16);
    load_and_run(hex_fold(acc));
  endtask

  task automatic input_reads();
    logic [31:0] r;
    logic [31:0] acc;
    take_bits(4, r);
    key = r[3:0];
    take_bits(10, r);
    sw = r[9:0];
    start_program();
    push_word(enc_imm(OP1_LW, 16'(`CPU_ADDRKEY), RZERO, RA));
    push_word(enc_imm(OP1_LW, 16'(`CPU_ADDRSW), RZERO, RB));
    push_word(enc_alur(OP2_LSHF, RA, RA, RC16));
    push_word(enc_alur(OP2_OR, RACC, RA, RB));
    finish_program();
    // KEY is active low
    acc = ({28'b0, ~key} << 16) | {22'b0, sw};
    load_and_run(hex_fold(acc));
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    imem_load  = '0;
    key        = '0;
    sw         = '0;
    lfsr_state = 32'ha353;
    @(negedge clk);
    check_reset_values();
    alu_reg_ops();
    alu_imm_ops();
    load_store();
    branches_and_jal();
    input_reads();
    if (i_dut.i_fetch.i_props.fail_count != 0) begin
      $display("fetch assertions failed %0d times", i_dut.i_fetch.i_props.fail_count);
      abort_run();
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- dv/cpu_props.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module cpu_props import cpu_pkg::*; (
  input logic                  clk,
  input logic                  reset,
  input logic [`CPU_DBITS-1:0] pc,
  input logic                  stall,
  input redirect_t             redirect,
  input logic [`CPU_DBITS-1:0] fe_inst
);

  // Count of failed assertions
  int fail_count = 0;

  // Instructions sit on 4-byte boundaries
  pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else begin
      $error("PC is not word aligned");
      fail_count++;
    end

  // Stall freezes the PC unless a redirect arrives
  pc_held: assert property (@(posedge clk) disable iff (reset)
    stall && !redirect.valid |=> pc == $past(pc))
    else begin
      $error("PC moved during stall");
      fail_count++;
    end

  // Wrong-path slot is squashed
  redirect_bubble: assert property (@(posedge clk) disable iff (reset)
    redirect.valid |=> fe_inst == '0)
    else begin
      $error("Fetch latch not a bubble after redirect");
      fail_count++;
    end

endmodule

bind cpu_fetch cpu_props i_props (
  .clk(clk), .reset(reset), .pc(pc), .stall(stall), .redirect(redirect), .fe_inst(fe_inst)
);

`default_nettype wire

//--- verilog/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module cpu_top import cpu_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  imem_load_t               imem_load,
  input  logic [`CPU_KEYBITS-1:0]  key,
  input  logic [`CPU_SWBITS-1:0]   sw,
  output logic [`CPU_HEXBITS-1:0]  hex,
  output logic [`CPU_LEDRBITS-1:0] ledr
);

  // Inter-stage wiring
  logic [`CPU_DBITS-1:0] fe_inst;
  logic [`CPU_DBITS-1:0] fe_pc;
  logic                  stall;
  logic                  fetch_bubble;
  redirect_t             redirect;
  id_ex_t                id_ex;
  ex_mem_t               ex_mem;
  mem_wb_t               mem_wb;

  cpu_fetch i_fetch (
    .clk(clk), .reset(reset), .imem_load(imem_load), .stall(stall),
    .fetch_bubble(fetch_bubble), .redirect(redirect), .fe_inst(fe_inst), .fe_pc(fe_pc)
  );

  // Decode also sees later stages for hazards and writeback
  cpu_decode i_decode (
    .clk(clk), .reset(reset), .fe_inst(fe_inst), .fe_pc(fe_pc), .ex_mem(ex_mem),
    .mem_wb(mem_wb), .stall(stall), .fetch_bubble(fetch_bubble), .id_ex(id_ex)
  );

  cpu_execute i_execute (
    .clk(clk), .reset(reset), .id_ex(id_ex), .redirect(redirect), .ex_mem(ex_mem)
  );

  cpu_memory i_memory (
    .clk(clk), .reset(reset), .ex_mem(ex_mem), .key(key), .sw(sw),
    .mem_wb(mem_wb), .hex(hex), .ledr(ledr)
  );

endmodule

`default_nettype wire

//--- verilog/cpu_memory.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module cpu_memory import cpu_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  ex_mem_t                  ex_mem,
  input  logic [`CPU_KEYBITS-1:0]  key,
  input  logic [`CPU_SWBITS-1:0]   sw,
  output mem_wb_t                  mem_wb,
  output logic [`CPU_HEXBITS-1:0]  hex,
  output logic [`CPU_LEDRBITS-1:0] ledr
);

  localparam int DMEMWORDS = 1 << (`CPU_DMEMADDRBITS - 2);

  logic [`CPU_DBITS-1:0]         dmem [DMEMWORDS];
  logic [`CPU_DMEMADDRBITS-3:0]  widx;
  logic                          is_hex;
  logic                          is_ledr;
  logic                          is_key;
  logic                          is_sw;
  logic [`CPU_DBITS-1:0]         rd_val;

  // Address decode
  assign widx    = ex_mem.aluout[`CPU_DMEMADDRBITS-1:2];
  assign is_hex  = (ex_mem.aluout == `CPU_ADDRHEX);
  assign is_ledr = (ex_mem.aluout == `CPU_ADDRLEDR);
  assign is_key  = (ex_mem.aluout == `CPU_ADDRKEY);
  assign is_sw   = (ex_mem.aluout == `CPU_ADDRSW);

  // ********************************************************
  // Data memory and I/O
  // ********************************************************
  // I/O stores never reach the array
  always_ff @(posedge clk) begin
    if (ex_mem.wr_mem && !is_hex && !is_ledr) begin
      dmem[widx] <= ex_mem.sdata;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex  <= `CPU_HEXRESET;
      ledr <= '0;
    end else if (ex_mem.wr_mem) begin
      if (is_hex) begin
        hex <= ex_mem.sdata[`CPU_HEXBITS-1:0];
      end
      if (is_ledr) begin
        ledr <= ex_mem.sdata[`CPU_LEDRBITS-1:0];
      end
    end
  end

  // KEY buttons are active low
  always_comb begin
    if (is_key) begin
      rd_val = {{(`CPU_DBITS-`CPU_KEYBITS){1'b0}}, ~key};
    end else if (is_sw) begin
      rd_val = {{(`CPU_DBITS-`CPU_SWBITS){1'b0}}, sw};
    end else begin
      rd_val = dmem[widx];
    end
  end

  // Memory latch, loads take the read value
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mem_wb <= '0;
    end else begin
      mem_wb.value  <= ex_mem.rd_mem ? rd_val : ex_mem.aluout;
      mem_wb.wregno <= ex_mem.wregno;
      mem_wb.wr_reg <= ex_mem.wr_reg;
    end
  end

endmodule

`default_nettype wire

//--- verilog/cpu_execute.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module cpu_execute import cpu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  id_ex_t    id_ex,
  output redirect_t redirect,
  output ex_mem_t   ex_mem
);

  logic [`CPU_DBITS-1:0] a;
  logic [`CPU_DBITS-1:0] b;
  logic [`CPU_DBITS-1:0] aluout;
  logic                  br_cond;
  logic [`CPU_DBITS-1:0] imm_off;
  logic [`CPU_DBITS-1:0] pc_plus;

  assign a       = id_ex.regval1;
  assign b       = id_ex.regval2;
  assign pc_plus = id_ex.pc + `CPU_INSTSIZE;
  // Immediate counts instructions
  assign imm_off = id_ex.imm << 2;

  // ********************************************************
  // ALU
  // ********************************************************
  always_comb begin
    aluout = '0;
    case (id_ex.op1)
      OP1_ALUR: begin
        case (id_ex.op2)
          // Signed compares give 0 or 1
          OP2_EQ:   aluout = {{(`CPU_DBITS-1){1'b0}}, a == b};
          OP2_LT:   aluout = {{(`CPU_DBITS-1){1'b0}}, $signed(a) < $signed(b)};
          OP2_LE:   aluout = {{(`CPU_DBITS-1){1'b0}}, $signed(a) <= $signed(b)};
          OP2_NE:   aluout = {{(`CPU_DBITS-1){1'b0}}, a != b};
          OP2_ADD:  aluout = a + b;
          OP2_AND:  aluout = a & b;
          OP2_OR:   aluout = a | b;
          OP2_XOR:  aluout = a ^ b;
          OP2_SUB:  aluout = a - b;
          OP2_NAND: aluout = ~(a & b);
          OP2_NOR:  aluout = ~(a | b);
          OP2_NXOR: aluout = ~(a ^ b);
          // Shift amount from low 5 bits, logical right
          OP2_RSHF: aluout = a >> b[4:0];
          OP2_LSHF: aluout = a << b[4:0];
          default:  aluout = '0;
        endcase
      end
      // Address generation shares the adder with ADDI
      OP1_ADDI, OP1_LW, OP1_SW: aluout = a + id_ex.imm;
      OP1_ANDI: aluout = a & id_ex.imm;
      OP1_ORI:  aluout = a | id_ex.imm;
      OP1_XORI: aluout = a ^ id_ex.imm;
      // Link value
      OP1_JAL:  aluout = pc_plus;
      default:  aluout = '0;
    endcase
  end

  always_comb begin
    case (id_ex.op1)
      OP1_BEQ: br_cond = (a == b);
      OP1_BLT: br_cond = ($signed(a) < $signed(b));
      OP1_BLE: br_cond = ($signed(a) <= $signed(b));
      OP1_BNE: br_cond = (a != b);
      default: br_cond = 1'b0;
    endcase
  end

  // Branch is PC-relative, JAL is rs-relative
  assign redirect.valid  = id_ex.valid && (id_ex.ctrl.is_jmp || (id_ex.ctrl.is_br && br_cond));
  assign redirect.target = id_ex.ctrl.is_jmp ? (a + imm_off) : (pc_plus + imm_off);

  // Execute latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_mem <= '0;
    end else begin
      ex_mem.aluout <= aluout;
      // Store data comes from rt
      ex_mem.sdata  <= b;
      ex_mem.wregno <= id_ex.wregno;
      ex_mem.rd_mem <= id_ex.valid && id_ex.ctrl.rd_mem;
      ex_mem.wr_mem <= id_ex.valid && id_ex.ctrl.wr_mem;
      ex_mem.wr_reg <= id_ex.valid && id_ex.ctrl.wr_reg;
    end
  end

endmodule

`default_nettype wire

//--- verilog/cpu_decode.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module cpu_decode import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`CPU_DBITS-1:0] fe_inst,
  input  logic [`CPU_DBITS-1:0] fe_pc,
  input  ex_mem_t               ex_mem,
  input  mem_wb_t               mem_wb,
  output logic                  stall,
  output logic                  fetch_bubble,
  output id_ex_t                id_ex
);

  localparam int REGWORDS = 1 << `CPU_REGNOBITS;

  op1_e                      op1;
  op2_e                      op2;
  logic [`CPU_IMMBITS-1:0]   imm;
  logic [`CPU_REGNOBITS-1:0] rd;
  logic [`CPU_REGNOBITS-1:0] rs;
  logic [`CPU_REGNOBITS-1:0] rt;
  logic [`CPU_DBITS-1:0]     imm_sx;
  logic                      op2_known;
  ctrl_t                     ctrl;
  logic [`CPU_REGNOBITS-1:0] wregno;
  logic [`CPU_DBITS-1:0]     regs [REGWORDS];

  // True when a pending write targets one of the sources
  function automatic logic src_hit(input logic [`CPU_REGNOBITS-1:0] wno,
                                   input logic                      wr,
                                   input logic [`CPU_REGNOBITS-1:0] a,
                                   input logic [`CPU_REGNOBITS-1:0] b);
    return wr && (wno != '0) && ((wno == a) || (wno == b));
  endfunction

  // Fixed field positions
  assign op1    = op1_e'(fe_inst[31:26]);
  assign op2    = op2_e'(fe_inst[25:18]);
  assign imm    = fe_inst[23:8];
  assign rd     = fe_inst[11:8];
  assign rs     = fe_inst[7:4];
  assign rt     = fe_inst[3:0];
  assign imm_sx = {{(`CPU_DBITS-`CPU_IMMBITS){imm[`CPU_IMMBITS-1]}}, imm};

  // Unknown op2 (bubble included) writes nothing
  always_comb begin
    case (op2)
      OP2_EQ, OP2_LT, OP2_LE, OP2_NE, OP2_ADD, OP2_AND, OP2_OR,
      OP2_XOR, OP2_SUB, OP2_NAND, OP2_NOR, OP2_NXOR, OP2_RSHF,
      OP2_LSHF: op2_known = 1'b1;
      default:  op2_known = 1'b0;
    endcase
  end

  // ********************************************************
  // Control decode
  // ********************************************************
  always_comb begin
    ctrl   = '0;
    wregno = '0;
    case (op1)
      OP1_ALUR: begin
        ctrl.wr_reg = op2_known;
        wregno      = rd;
      end
      OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE: ctrl.is_br = 1'b1;
      OP1_JAL: begin
        ctrl.is_jmp = 1'b1;
        ctrl.wr_reg = 1'b1;
        wregno      = rt;
      end
      OP1_LW: begin
        ctrl.rd_mem = 1'b1;
        ctrl.wr_reg = 1'b1;
        wregno      = rt;
      end
      OP1_SW: ctrl.wr_mem = 1'b1;
      OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI: begin
        ctrl.wr_reg = 1'b1;
        wregno      = rt;
      end
      default: ctrl = '0;
    endcase
  end

  // Hold decode while a source waits on execute, memory or writeback
  assign stall = src_hit(id_ex.wregno, id_ex.ctrl.wr_reg, rs, rt) ||
                 src_hit(ex_mem.wregno, ex_mem.wr_reg, rs, rt) ||
                 src_hit(mem_wb.wregno, mem_wb.wr_reg, rs, rt);

  // No prediction, so fetch idles until execute resolves
  assign fetch_bubble = ctrl.is_br || ctrl.is_jmp || id_ex.ctrl.is_br || id_ex.ctrl.is_jmp;

  // Register file, writeback on the falling edge
  always_ff @(negedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < REGWORDS; i++) begin
        regs[i] <= '0;
      end
    end else if (mem_wb.wr_reg) begin
      regs[mem_wb.wregno] <= mem_wb.value;
    end
  end

  // Decode latch, bubble on stall
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_ex <= '0;
    end else if (stall) begin
      id_ex <= '0;
    end else begin
      id_ex.valid   <= 1'b1;
      id_ex.pc      <= fe_pc;
      id_ex.op1     <= op1;
      id_ex.op2     <= op2;
      id_ex.regval1 <= regs[rs];
      id_ex.regval2 <= regs[rt];
      id_ex.imm     <= imm_sx;
      id_ex.wregno  <= wregno;
      id_ex.ctrl    <= ctrl;
    end
  end

endmodule

`default_nettype wire

//--- verilog/cpu_fetch.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module cpu_fetch import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  imem_load_t            imem_load,
  input  logic                  stall,
  input  logic                  fetch_bubble,
  input  redirect_t             redirect,
  output logic [`CPU_DBITS-1:0] fe_inst,
  output logic [`CPU_DBITS-1:0] fe_pc
);

  localparam int IMEMWORDS = 1 << (`CPU_IMEMADDRBITS - 2);

  logic [`CPU_DBITS-1:0] pc;
  logic [`CPU_DBITS-1:0] imem [IMEMWORDS];
  logic [`CPU_DBITS-1:0] inst_rd;

  // Word-addressed instruction memory, loaded from outside
  always_ff @(posedge clk) begin
    if (imem_load.en) begin
      imem[imem_load.addr[`CPU_IMEMADDRBITS-1:2]] <= imem_load.inst;
    end
  end

  assign inst_rd = imem[pc[`CPU_IMEMADDRBITS-1:2]];

  // ********************************************************
  // PC and fetch latch
  // ********************************************************
  // Redirect wins, then stall, then bubble
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc      <= `CPU_STARTPC;
      fe_inst <= '0;
      fe_pc   <= '0;
    end else if (redirect.valid) begin
      pc      <= redirect.target;
      fe_inst <= '0;
    end else if (stall) begin
      // Hold both PC and latch
      pc <= pc;
    end else if (fetch_bubble) begin
      // Wait for the control transfer to resolve
      fe_inst <= '0;
    end else begin
      pc      <= pc + `CPU_INSTSIZE;
      fe_inst <= inst_rd;
      fe_pc   <= pc;
    end
  end

endmodule

`default_nettype wire

//--- verilog/cpu_pkg.sv
`default_nettype none
`include "cpu_config.svh"

package cpu_pkg;

  // Primary opcode, inst[31:26]
  typedef enum logic [5:0] {
    OP1_ALUR = 6'b000000,
    OP1_BEQ  = 6'b001000,
    OP1_BLT  = 6'b001001,
    OP1_BLE  = 6'b001010,
    OP1_BNE  = 6'b001011,
    OP1_JAL  = 6'b001100,
    OP1_LW   = 6'b010010,
    OP1_SW   = 6'b011010,
    OP1_ADDI = 6'b100000,
    OP1_ANDI = 6'b100100,
    OP1_ORI  = 6'b100101,
    OP1_XORI = 6'b100110
  } op1_e;

  // Secondary opcode, inst[25:18], only meaningful under OP1_ALUR
  typedef enum logic [7:0] {
    OP2_EQ   = 8'b00001000,
    OP2_LT   = 8'b00001001,
    OP2_LE   = 8'b00001010,
    OP2_NE   = 8'b00001011,
    OP2_ADD  = 8'b00100000,
    OP2_AND  = 8'b00100100,
    OP2_OR   = 8'b00100101,
    OP2_XOR  = 8'b00100110,
    OP2_SUB  = 8'b00101000,
    OP2_NAND = 8'b00101100,
    OP2_NOR  = 8'b00101101,
    OP2_NXOR = 8'b00101110,
    OP2_RSHF = 8'b00110000,
    OP2_LSHF = 8'b00110001
  } op2_e;

  // Instruction memory write port
  typedef struct packed {
    logic                         en;
    logic [`CPU_IMEMADDRBITS-1:0] addr;
    logic [`CPU_DBITS-1:0]        inst;
  } imem_load_t;

  typedef struct packed {
    logic is_br;
    logic is_jmp;
    logic rd_mem;
    logic wr_mem;
    logic wr_reg;
  } ctrl_t;

  // ********************************************************
  // Stage-to-stage payloads
  // ********************************************************
  typedef struct packed {
    logic                      valid;
    logic [`CPU_DBITS-1:0]     pc;
    op1_e                      op1;
    op2_e                      op2;
    logic [`CPU_DBITS-1:0]     regval1;
    logic [`CPU_DBITS-1:0]     regval2;
    logic [`CPU_DBITS-1:0]     imm;
    logic [`CPU_REGNOBITS-1:0] wregno;
    ctrl_t                     ctrl;
  } id_ex_t;

  typedef struct packed {
    logic [`CPU_DBITS-1:0]     aluout;
    logic [`CPU_DBITS-1:0]     sdata;
    logic [`CPU_REGNOBITS-1:0] wregno;
    logic                      rd_mem;
    logic                      wr_mem;
    logic                      wr_reg;
  } ex_mem_t;

  typedef struct packed {
    logic [`CPU_DBITS-1:0]     value;
    logic [`CPU_REGNOBITS-1:0] wregno;
    logic                      wr_reg;
  } mem_wb_t;

  // Taken branch or JAL
  typedef struct packed {
    logic                  valid;
    logic [`CPU_DBITS-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire

//--- include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath widths
`define CPU_DBITS        32
`define CPU_REGNOBITS    4
`define CPU_IMMBITS      16
`define CPU_INSTSIZE     32'd4
`define CPU_STARTPC      32'h0000_0100

// Byte-address bits decoded by each memory
`define CPU_IMEMADDRBITS 16
`define CPU_DMEMADDRBITS 16

// Memory-mapped I/O addresses
`define CPU_ADDRHEX      32'hFFFF_F000
`define CPU_ADDRLEDR     32'hFFFF_F020
`define CPU_ADDRKEY      32'hFFFF_F080
`define CPU_ADDRSW       32'hFFFF_F090

// I/O widths and reset values
`define CPU_HEXBITS      24
`define CPU_LEDRBITS     10
`define CPU_KEYBITS      4
`define CPU_SWBITS       10
`define CPU_HEXRESET     24'hFEDEAD

`endif
